// File: degu_trace.f
+incdir+verilog
verilog/trace_pkg.sv
verilog/ifu_tracker.sv
verilog/lsu_tracker.sv
verilog/trace_assembler.sv
verilog/degu_trace_top.sv
verification/degu_trace_tb.sv

// File: Bender.yml
package:
  name: degu_trace

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/trace_pkg.sv
      - verilog/ifu_tracker.sv
      - verilog/lsu_tracker.sv
      - verilog/trace_assembler.sv
      - verilog/degu_trace_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/degu_trace_tb.sv

// File: verification/degu_trace_tb.sv
//////////////////////////////////////////////////
// execution trace unit testbench
// random fetch and data bus traffic from a fixed
// seed, expected records built by a model queue
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module degu_trace_tb
    import trace_pkg::*;
();

    localparam int          CLK_HALF  = 50;     // 100 ns period
    localparam int          RST_CYC   = 5;
    localparam int          NUM_FETCH = 2000;
    localparam int          WDOG_NS   = NUM_FETCH * 2 * 2 * CLK_HALF + 10_000;
    localparam logic [31:0] SEED      = 32'hc78c_f3ea;

    // DUT pins
    logic                   tcb_ifu;
    logic                   reset;
    logic                   ifu_trn;
    tcb_req_t               ifu_req;
    tcb_rsp_t               ifu_rsp;
    logic                   lsu_trn;
    tcb_req_t               lsu_req;
    tcb_rsp_t               lsu_rsp;
    logic                   gpr_den;
    logic [`TRACE_GLOG-1:0] gpr_did;
    logic [`TRACE_XLEN-1:0] gpr_ddt;
    logic [`TRACE_GLOG-1:0] gpr_sid;
    logic                   trace_vld;
    trace_rec_t             trace_rec;

    // model state
    trace_rec_t             exp_q[$];  // expected records, oldest first
    int                     due_q[$];  // cycle each record must strobe in
    int                     cyc;       // drive cycle count
    int                     err_cnt;
    int                     rec_cnt;
    int                     exp_seq;
    logic                   checking;

    // fetch one cycle old, response goes out now
    logic                   s1_vld;
    logic [`TRACE_XLEN-1:0] s1_adr;
    logic [`TRACE_XLEN-1:0] s1_ins;
    ins_size_e              s1_siz;
    // fetch two cycles old plus its paired data transfer
    logic                   s2_vld;
    logic [`TRACE_XLEN-1:0] s2_adr;
    logic [`TRACE_XLEN-1:0] s2_ins;
    ins_size_e              s2_siz;
    lsu_op_e                s2_op;
    logic [`TRACE_XLEN-1:0] s2_dadr;
    logic [1:0]             s2_dsiz;
    logic [`TRACE_GLOG-1:0] s2_wid;
    logic [`TRACE_XLEN-1:0] s2_wdt;

    degu_trace_top UUT (
        .tcb_ifu   (tcb_ifu),
        .reset     (reset),
        .ifu_trn   (ifu_trn),
        .ifu_req   (ifu_req),
        .ifu_rsp   (ifu_rsp),
        .lsu_trn   (lsu_trn),
        .lsu_req   (lsu_req),
        .lsu_rsp   (lsu_rsp),
        .gpr_den   (gpr_den),
        .gpr_did   (gpr_did),
        .gpr_ddt   (gpr_ddt),
        .gpr_sid   (gpr_sid),
        .trace_vld (trace_vld),
        .trace_rec (trace_rec)
    );

    initial begin
        tcb_ifu = 1'b0;
        forever #(CLK_HALF) tcb_ifu = ~tcb_ifu;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // random word forced into one length class
    function automatic logic [31:0] make_ins(input int cls);
        logic [31:0] ins;
        ins = $urandom;
        case (cls)
            0:       ins[1:0] = 2'($urandom_range(0, 2));   // 16 bit
            1: begin
                ins[1:0] = 2'b11;
                ins[4:2] = 3'($urandom_range(0, 6));        // 32 bit
            end
            default: ins[4:0] = 5'b11111;                   // 48 bit and up
        endcase
        return ins;
    endfunction

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_record(input trace_rec_t exp, input trace_rec_t act);
        check_field("trace_rec.seq", exp.seq, act.seq);
        check_field("trace_rec.ifu.adr", exp.ifu.adr, act.ifu.adr);
        check_field("trace_rec.ifu.ins", exp.ifu.ins, act.ifu.ins);
        check_field("trace_rec.ifu.siz", exp.ifu.siz, act.ifu.siz);
        check_field("trace_rec.ifu.ill", exp.ifu.ill, act.ifu.ill);
        check_field("trace_rec.wbu.ena", exp.wbu.ena, act.wbu.ena);
        check_field("trace_rec.wbu.idx", exp.wbu.idx, act.wbu.idx);
        check_field("trace_rec.wbu.dat", exp.wbu.dat, act.wbu.dat);
        check_field("trace_rec.lsu.op", exp.lsu.op, act.lsu.op);
        check_field("trace_rec.lsu.adr", exp.lsu.adr, act.lsu.adr);
        check_field("trace_rec.lsu.siz", exp.lsu.siz, act.lsu.siz);
        check_field("trace_rec.lsu.wid", exp.lsu.wid, act.lsu.wid);
        check_field("trace_rec.lsu.wdt", exp.lsu.wdt, act.lsu.wdt);
        check_field("trace_rec.lsu.rdt", exp.lsu.rdt, act.lsu.rdt);
        check_field("trace_rec.rid", exp.rid, act.rid);
    endtask

    //////////////////////////////////////////////////
    // one bus cycle, called right after a rising edge
    //////////////////////////////////////////////////

    task automatic drive_cycle(input logic do_fetch);
        tcb_req_t               freq;
        tcb_req_t               dreq;
        trace_rec_t             exp;
        logic                   den;
        logic [`TRACE_GLOG-1:0] did;
        logic [`TRACE_GLOG-1:0] sid;
        logic [`TRACE_XLEN-1:0] ddt;
        logic [`TRACE_XLEN-1:0] rdt;
        logic                   take;
        int                     cls;

        den = ($urandom_range(0, 1) == 1);  // write-back pins random each cycle
        did = `TRACE_GLOG'($urandom);
        ddt = $urandom;
        rdt = $urandom;
        gpr_den     <= den;
        gpr_did     <= did;
        gpr_ddt     <= ddt;
        lsu_rsp.rdt <= rdt;  // answers last cycle's data transfer

        // fetch from two cycles back is complete now
        if (s2_vld) begin
            exp         = '0;
            exp.seq     = exp_seq;
            exp.ifu.adr = s2_adr;
            exp.ifu.ins = s2_ins;
            exp.ifu.siz = s2_siz;
            exp.ifu.ill = (s2_siz == INS_LONG);
            exp.wbu.ena = den;
            if (den) begin
                exp.wbu.idx = did;
                exp.wbu.dat = ddt;
            end
            exp.lsu.op = s2_op;
            if (s2_op != LSU_NONE) begin
                exp.lsu.adr = s2_dadr;
                exp.lsu.siz = s2_dsiz;
                exp.lsu.wid = s2_wid;
            end
            if (s2_op == LSU_STORE) begin
                exp.lsu.wdt = s2_wdt;
            end
            if (s2_op == LSU_LOAD) begin
                exp.lsu.rdt = rdt;
                exp.rid     = did;  // load target is this cycle's write-back
            end
            exp_seq++;
            exp_q.push_back(exp);
            due_q.push_back(cyc + 1);
        end

        // data transfer pairs only with the fetch one cycle back
        take     = s1_vld && ($urandom_range(0, 1) == 1);
        dreq.adr = $urandom;
        dreq.wdt = $urandom;
        dreq.siz = 2'($urandom_range(0, 2));
        dreq.wen = 1'b0;
        dreq.ren = 1'b0;
        if (take) begin
            if ($urandom_range(0, 1) == 1) begin
                dreq.wen = 1'b1;
            end else begin
                dreq.ren = 1'b1;
            end
        end
        sid = `TRACE_GLOG'($urandom);
        lsu_trn     <= take;
        lsu_req     <= dreq;
        gpr_sid     <= sid;
        ifu_rsp.rdt <= s1_vld ? s1_ins : $urandom;  // junk when nothing pending

        s2_vld  = s1_vld;
        s2_adr  = s1_adr;
        s2_ins  = s1_ins;
        s2_siz  = s1_siz;
        s2_op   = !take ? LSU_NONE : (dreq.wen ? LSU_STORE : LSU_LOAD);
        s2_dadr = dreq.adr;
        s2_dsiz = dreq.siz;
        s2_wid  = sid;
        s2_wdt  = dreq.wdt;

        // new fetch, halfword aligned PC
        cls        = $urandom_range(0, 2);
        freq.adr   = $urandom;
        freq.adr[0] = 1'b0;
        freq.wen   = 1'b0;
        freq.ren   = 1'b1;
        freq.siz   = 2'd2;
        freq.wdt   = '0;
        ifu_trn   <= do_fetch;
        ifu_req   <= freq;
        s1_vld     = do_fetch;
        s1_adr     = freq.adr;
        s1_ins     = make_ins(cls);
        s1_siz     = (cls == 0) ? INS_16 : ((cls == 1) ? INS_32 : INS_LONG);
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin : stimulus
        int   issued;
        int   gap;
        logic do_fetch;

        void'($urandom(SEED));
        reset    = 1'b1;
        ifu_trn  = 1'b0;
        ifu_req  = '0;
        ifu_rsp  = '0;
        lsu_trn  = 1'b0;
        lsu_req  = '0;
        lsu_rsp  = '0;
        gpr_den  = 1'b0;
        gpr_did  = '0;
        gpr_ddt  = '0;
        gpr_sid  = '0;
        cyc      = 0;
        err_cnt  = 0;
        rec_cnt  = 0;
        exp_seq  = 0;
        checking = 1'b0;
        s1_vld   = 1'b0;
        s2_vld   = 1'b0;

        repeat (RST_CYC) @(posedge tcb_ifu);
        reset   <= 1'b0;
        checking = 1'b1;

        issued = 0;
        gap    = 3;  // a few quiet cycles after reset
        while (issued < NUM_FETCH) begin
            @(posedge tcb_ifu);
            cyc++;
            do_fetch = (gap == 0);
            if (do_fetch) begin
                issued++;
                gap = $urandom_range(0, 1);
            end else begin
                gap--;
            end
            drive_cycle(do_fetch);
        end
        repeat (4) begin  // let the last records drain
            @(posedge tcb_ifu);
            cyc++;
            drive_cycle(1'b0);
        end
        @(posedge tcb_ifu);

        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected records never came out", exp_q.size());
        end
        if (rec_cnt != NUM_FETCH) begin
            err_cnt++;
            $display("saw %0d records for %0d fetches", rec_cnt, NUM_FETCH);
        end
        $display("records: %0d, errors: %0d", rec_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    //////////////////////////////////////////////////
    // output check, mid cycle
    //////////////////////////////////////////////////

    initial begin : monitor
        trace_rec_t exp;
        int         due;
        forever begin
            @(negedge tcb_ifu);
            if (checking) begin
                if (trace_vld === 1'b1) begin
                    rec_cnt++;
                    if (exp_q.size() == 0) begin
                        err_cnt++;
                        $display("%0t: trace_vld strobed with no record due", $time);
                    end else begin
                        exp = exp_q.pop_front();
                        due = due_q.pop_front();
                        if (due != cyc) begin
                            err_cnt++;
                            $display("%0t: record seq %0d came in cycle %0d, due in %0d",
                                     $time, exp.seq, cyc, due);
                        end
                        check_record(exp, trace_rec);
                    end
                end else if (trace_vld !== 1'b0) begin
                    err_cnt++;
                    $display("%0t: trace_vld is unknown", $time);
                end else if (due_q.size() != 0 && due_q[0] <= cyc) begin
                    err_cnt++;
                    $display("%0t: record seq %0d due in cycle %0d never strobed",
                             $time, exp_q[0].seq, due_q[0]);
                    exp = exp_q.pop_front();
                    due = due_q.pop_front();
                end
            end
        end
    end

    // hard stop if the run hangs
    initial begin : watchdog
        #(WDOG_NS);
        $display("timeout after %0d ns, the run did not finish", WDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule: degu_trace_tb

`default_nettype wire

// File: verilog/degu_trace_top.sv
//////////////////////////////////////////////////
// execution trace unit top
// fetch and data trackers side by side, merged
// by the record assembler
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module degu_trace_top
    import trace_pkg::*;
(
    input  wire                         tcb_ifu,  // clock
    input  wire                         reset,    // sync, active high
    // TCB instruction bus
    input  wire                         ifu_trn,
    input  wire tcb_req_t               ifu_req,
    input  wire tcb_rsp_t               ifu_rsp,
    // TCB data bus
    input  wire                         lsu_trn,
    input  wire tcb_req_t               lsu_req,
    input  wire tcb_rsp_t               lsu_rsp,
    // GPR array
    input  wire                         gpr_den,  // destination enable
    input  wire [`TRACE_GLOG-1:0]       gpr_did,  // destination index
    input  wire [`TRACE_XLEN-1:0]       gpr_ddt,  // destination data
    input  wire [`TRACE_GLOG-1:0]       gpr_sid,  // source index
    // trace out, fetch n -> strobe n+3
    output logic                        trace_vld,
    output trace_rec_t                  trace_rec
);

    // tracker results
    logic     ifu_vld;
    ifu_rec_t ifu_rec;
    logic     lsu_vld;
    lsu_rec_t lsu_rec;

    ifu_tracker ifu_trk (
        .tcb_ifu (tcb_ifu),
        .reset   (reset),
        .ifu_trn (ifu_trn),
        .ifu_req (ifu_req),
        .ifu_rsp (ifu_rsp),
        .ifu_vld (ifu_vld),
        .ifu_rec (ifu_rec)
    );

    lsu_tracker lsu_trk (
        .tcb_ifu (tcb_ifu),
        .reset   (reset),
        .lsu_trn (lsu_trn),
        .lsu_req (lsu_req),
        .lsu_rsp (lsu_rsp),
        .gpr_sid (gpr_sid),
        .lsu_vld (lsu_vld),
        .lsu_rec (lsu_rec)
    );

    trace_assembler asm_i (
        .tcb_ifu   (tcb_ifu),
        .reset     (reset),
        .ifu_vld   (ifu_vld),
        .ifu_rec   (ifu_rec),
        .lsu_vld   (lsu_vld),
        .lsu_rec   (lsu_rec),
        .gpr_den   (gpr_den),
        .gpr_did   (gpr_did),
        .gpr_ddt   (gpr_ddt),
        .trace_vld (trace_vld),
        .trace_rec (trace_rec)
    );

endmodule: degu_trace_top

`default_nettype wire

// File: verilog/trace_assembler.sv
//////////////////////////////////////////////////
// trace record assembler
// merges fetch and data records with the live
// GPR write-back and numbers each record
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module trace_assembler
    import trace_pkg::*;
(
    input  wire                         tcb_ifu,  // clock
    input  wire                         reset,    // sync, active high
    // fetch tracker
    input  wire                         ifu_vld,
    input  wire ifu_rec_t               ifu_rec,
    // data tracker
    input  wire                         lsu_vld,
    input  wire lsu_rec_t               lsu_rec,
    // GPR write-back, sampled live
    input  wire                         gpr_den,
    input  wire [`TRACE_GLOG-1:0]       gpr_did,
    input  wire [`TRACE_XLEN-1:0]       gpr_ddt,
    // trace out, one cycle strobe, no back-pressure
    output logic                        trace_vld,
    output trace_rec_t                  trace_rec
);

    //////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////

    logic [`TRACE_SEQW-1:0] seq_cnt;  // number of the next record
    lsu_rec_t               lsu_sel;
    wbu_rec_t               wbu_sel;
    logic [`TRACE_GLOG-1:0] rid_sel;

    //////////////////////////////////////////////////
    // field select
    //////////////////////////////////////////////////

    // data part, empty record when no transfer paired
    always_comb begin
        if (lsu_vld) begin
            lsu_sel = lsu_rec;
        end else begin
            lsu_sel    = '0;
            lsu_sel.op = LSU_NONE;
        end
    end

    // write-back, payload zeroed when disabled
    always_comb begin
        wbu_sel.ena = gpr_den;
        wbu_sel.idx = gpr_den ? gpr_did : '0;
        wbu_sel.dat = gpr_den ? gpr_ddt : '0;
    end

    // load destination shares the write-back index
    assign rid_sel = (lsu_vld && (lsu_rec.op == LSU_LOAD)) ? gpr_did : '0;

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (reset) begin
            trace_vld <= 1'b0;
            seq_cnt   <= '0;
        end else begin
            trace_vld <= ifu_vld;
            if (ifu_vld) begin
                seq_cnt <= seq_cnt + 1'b1;  // once per record
            end
        end
    end

    always_ff @(posedge tcb_ifu) begin
        if (ifu_vld) begin
            trace_rec.seq <= seq_cnt;
            trace_rec.ifu <= ifu_rec;
            trace_rec.wbu <= wbu_sel;
            trace_rec.lsu <= lsu_sel;
            trace_rec.rid <= rid_sel;
        end
    end

    // a data transfer always pairs with a fetch one cycle older
    assert property (@(posedge tcb_ifu) disable iff (reset)
        lsu_vld |-> ifu_vld);

endmodule: trace_assembler

`default_nettype wire

// File: verilog/lsu_tracker.sv
//////////////////////////////////////////////////
// load/store tracker
// registers a data bus request with its source
// GPR and joins the response into a data record
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module lsu_tracker
    import trace_pkg::*;
(
    input  wire                         tcb_ifu,  // clock
    input  wire                         reset,    // sync, active high
    // TCB data bus monitor
    input  wire                         lsu_trn,
    input  wire tcb_req_t               lsu_req,
    input  wire tcb_rsp_t               lsu_rsp,
    // store source register index
    input  wire [`TRACE_GLOG-1:0]       gpr_sid,
    // data record out, lined up with the owning fetch record
    output logic                        lsu_vld,
    output lsu_rec_t                    lsu_rec
);

    //////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////

    lsu_op_e                req_op;   // op of live request
    // request stage
    lsu_op_e                lsu_op;
    logic [`TRACE_XLEN-1:0] lsu_adr;
    logic [2-1:0]           lsu_siz;
    logic [`TRACE_GLOG-1:0] lsu_wid;
    logic [`TRACE_XLEN-1:0] lsu_wdt;

    // wen/ren to opcode
    always_comb begin
        if (lsu_req.wen) begin
            req_op = LSU_STORE;
        end else if (lsu_req.ren) begin
            req_op = LSU_LOAD;
        end else begin
            req_op = LSU_NONE;
        end
    end

    //////////////////////////////////////////////////
    // request stage
    //////////////////////////////////////////////////

    always_ff @(posedge tcb_ifu) begin
        if (reset) begin
            lsu_vld <= 1'b0;
        end else begin
            lsu_vld <= lsu_trn;  // valid in the response cycle
        end
    end

    always_ff @(posedge tcb_ifu) begin
        if (lsu_trn) begin
            lsu_op  <= req_op;
            lsu_adr <= lsu_req.adr;
            lsu_siz <= lsu_req.siz;
            lsu_wid <= gpr_sid;  // source index comes with the request
            lsu_wdt <= lsu_req.wen ? lsu_req.wdt : '0;  // stores only
        end
    end

    // response joined live, loads only
    always_comb begin
        lsu_rec.op  = lsu_op;
        lsu_rec.adr = lsu_adr;
        lsu_rec.siz = lsu_siz;
        lsu_rec.wid = lsu_wid;
        lsu_rec.wdt = lsu_wdt;
        lsu_rec.rdt = (lsu_op == LSU_LOAD) ? lsu_rsp.rdt : '0;
    end

    // single direction per transfer
    assert property (@(posedge tcb_ifu) disable iff (reset)
        lsu_trn |-> !(lsu_req.wen && lsu_req.ren));

endmodule: lsu_tracker

`default_nettype wire

// File: verilog/ifu_tracker.sv
//////////////////////////////////////////////////
// instruction fetch tracker
// two stage capture of fetch address and returned
// word, with length and illegal encoding decode
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "trace_settings.svh"

module ifu_tracker
    import trace_pkg::*;
(
    input  wire                   tcb_ifu,  // clock
    input  wire                   reset,    // sync, active high
    // TCB instruction bus monitor
    input  wire                   ifu_trn,
    input  wire tcb_req_t         ifu_req,
    input  wire tcb_rsp_t         ifu_rsp,
    // fetch record out, n+2
    output logic                  ifu_vld,
    output ifu_rec_t              ifu_rec
);

    //////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////

    logic                   ifu_pnd;  // fetch waiting for its response
    logic [`TRACE_XLEN-1:0] ifu_pad;  // address of pending fetch
    ins_size_e              dec_siz;  // decoded length of live word
    logic                   dec_ill;

    //////////////////////////////////////////////////
    // length decode
    //////////////////////////////////////////////////

    // RISC-V length encoding, only 16/32 bit supported
    always_comb begin
        if (ifu_rsp.rdt[1:0] != 2'b11) begin
            dec_siz = INS_16;    // compressed
            dec_ill = 1'b0;
        end else if (ifu_rsp.rdt[4:2] != 3'b111) begin
            dec_siz = INS_32;
            dec_ill = 1'b0;
        end else begin
            dec_siz = INS_LONG;  // 48 bit or longer
            dec_ill = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // capture pipe
    //////////////////////////////////////////////////

    // control, n -> pending, n+1 -> valid
    always_ff @(posedge tcb_ifu) begin
        if (reset) begin
            ifu_pnd <= 1'b0;
            ifu_vld <= 1'b0;
        end else begin
            ifu_pnd <= ifu_trn;
            ifu_vld <= ifu_pnd;
        end
    end

    // payload
    always_ff @(posedge tcb_ifu) begin
        if (ifu_trn) begin
            ifu_pad <= ifu_req.adr;  // request valid with trn
        end
        if (ifu_pnd) begin
            ifu_rec.adr <= ifu_pad;
            ifu_rec.ins <= ifu_rsp.rdt;  // response one cycle later
            ifu_rec.siz <= dec_siz;
            ifu_rec.ill <= dec_ill;
        end
    end

    // PC always at least halfword aligned
    assert property (@(posedge tcb_ifu) disable iff (reset)
        ifu_trn |-> (ifu_req.adr[0] == 1'b0));

endmodule: ifu_tracker

`default_nettype wire

// File: verilog/trace_pkg.sv
//////////////////////////////////////////////////
// trace unit package
// TCB bus structs, per unit records, the full
// trace record and the state/opcode enums
//////////////////////////////////////////////////

`default_nettype none

`include "trace_settings.svh"

package trace_pkg;

    //////////////////////////////////////////////////
    // TCB bus
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`TRACE_XLEN-1:0] adr;  // address
        logic                   wen;  // write enable
        logic                   ren;  // read enable
        logic [2-1:0]           siz;  // logarithmic size
        logic [`TRACE_XLEN-1:0] wdt;  // write data
    } tcb_req_t;

    typedef struct packed {
        logic [`TRACE_XLEN-1:0] rdt;  // read data, one cycle after trn
    } tcb_rsp_t;

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    // instruction length from the low opcode bits
    typedef enum logic [1:0] {
        INS_16   = 2'd0,
        INS_32   = 2'd1,
        INS_LONG = 2'd2  // 48 bits and up, not supported
    } ins_size_e;

    // data bus operation
    typedef enum logic [1:0] {
        LSU_NONE  = 2'd0,
        LSU_LOAD  = 2'd1,
        LSU_STORE = 2'd2
    } lsu_op_e;

    //////////////////////////////////////////////////
    // records
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`TRACE_XLEN-1:0] adr;  // PC
        logic [`TRACE_XLEN-1:0] ins;  // instruction word
        ins_size_e              siz;  // decoded length
        logic                   ill;  // illegal length encoding
    } ifu_rec_t;

    typedef struct packed {
        lsu_op_e                op;
        logic [`TRACE_XLEN-1:0] adr;
        logic [2-1:0]           siz;
        logic [`TRACE_GLOG-1:0] wid;  // store source GPR
        logic [`TRACE_XLEN-1:0] wdt;  // store data, else zero
        logic [`TRACE_XLEN-1:0] rdt;  // load data, else zero
    } lsu_rec_t;

    typedef struct packed {
        logic                   ena;  // write-back enable
        logic [`TRACE_GLOG-1:0] idx;  // destination GPR
        logic [`TRACE_XLEN-1:0] dat;  // destination data
    } wbu_rec_t;

    typedef struct packed {
        logic [`TRACE_SEQW-1:0] seq;  // running record number
        ifu_rec_t               ifu;
        wbu_rec_t               wbu;
        lsu_rec_t               lsu;
        logic [`TRACE_GLOG-1:0] rid;  // load destination GPR
    } trace_rec_t;

endpackage: trace_pkg

`default_nettype wire

// File: verilog/trace_settings.svh
//////////////////////////////////////////////////
// trace unit settings
// widths shared by the package and the trackers
//////////////////////////////////////////////////

`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// data bus and address width
`define TRACE_XLEN 32

// register file
`define TRACE_GNUM 32  // number of GPRs
`define TRACE_GLOG 5   // GPR index width, log2 of GNUM

// record numbering
`define TRACE_SEQW 32  // sequence counter width

`endif
